// File: compile.f
+incdir+rtl
rtl/gf_types_pkg.sv
rtl/axi_regs_pkg.sv
rtl/gf_div_if.sv
rtl/gf_mult.sv
rtl/gf_divider.sv
rtl/gf_ctrl.sv
rtl/gf_alu_top.sv
verification/gf_alu_assert.sv
verification/tb_checker.sv
verification/tb_top.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_top -Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/tb_sim +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "TB PASSED"; then
	exit 0
fi
exit 1

// File: verification/gf_stimulus.txt
// kind addr wdata exp_data exp_resp in hex. Kind 01 write, 02 read, 03 poll STATUS until idle
// Kind bit 4 turns off bready and rready stalls. Kind ff ends the list
02 0C 00 00 0
02 10 00 00 0
02 00 00 00 0
02 04 00 00 0
01 00 02 00 0
01 04 80 00 0
01 08 01 00 0
02 10 00 1D 0
01 08 00 00 0
02 10 00 82 0
01 00 5C 00 0
01 04 01 00 0
01 08 01 00 0
02 10 00 5C 0
01 00 1D 00 0
01 04 02 00 0
11 08 02 00 0
12 10 00 5C 0
03 0C 00 00 0
02 10 00 80 0
01 00 80 00 0
01 08 01 00 0
02 10 00 1D 0
11 08 03 00 0
11 08 01 00 2
03 0C 00 00 0
02 10 00 8E 0
01 00 8E 00 0
01 08 01 00 0
02 10 00 01 0
01 08 02 00 0
03 0C 00 00 0
02 10 00 47 0
01 04 00 00 0
01 08 02 00 0
02 0C 00 02 0
02 10 00 00 0
01 08 01 00 0
02 0C 00 00 0
02 14 00 00 2
01 18 55 00 2
01 10 33 00 2
02 10 00 00 0
01 00 80 00 0
01 04 80 00 0
01 08 01 00 0
02 10 00 13 0
ff 00 00 00 0

// File: verification/tb_top.sv
`timescale 1ns/1ps

module tb_top;
	localparam int MAX_LINES = 64;

	logic clk, reset;
	axi_regs_pkg::reg_addr_t s_awaddr, s_araddr;
	logic s_awvalid, s_awready, s_wvalid, s_wready, s_bvalid, s_bready;
	logic s_arvalid, s_arready, s_rvalid, s_rready;
	logic [31:0] s_wdata, s_rdata;
	logic [3:0] s_wstrb;
	axi_regs_pkg::axi_resp_t s_bresp, s_rresp;

	logic [7:0] stim [MAX_LINES*5]; // Five columns per test line
	logic [7:0] kind;
	logic [31:0] exp_data, rd_value;
	logic [1:0] exp_resp;
	logic check_en, stall_en;
	integer seed = 32'h2a4f0160;
	int cycles, limit, n_tests, idx, bad_lines, hs_errs, test_num, wr_sent, rd_sent;
	int pass_cnt, fail_cnt, b_cnt, r_cnt;

	gf_alu_top dut_i (
		.clk(clk), .reset(reset),
		.s_awaddr(s_awaddr), .s_awvalid(s_awvalid), .s_awready(s_awready),
		.s_wdata(s_wdata), .s_wstrb(s_wstrb), .s_wvalid(s_wvalid), .s_wready(s_wready),
		.s_bresp(s_bresp), .s_bvalid(s_bvalid), .s_bready(s_bready),
		.s_araddr(s_araddr), .s_arvalid(s_arvalid), .s_arready(s_arready),
		.s_rdata(s_rdata), .s_rresp(s_rresp), .s_rvalid(s_rvalid), .s_rready(s_rready)
	);

	tb_checker chk_i (
		.clk(clk), .reset(reset),
		.bvalid(s_bvalid), .bready(s_bready), .bresp(s_bresp),
		.rvalid(s_rvalid), .rready(s_rready), .rresp(s_rresp), .rdata(s_rdata),
		.check_en(check_en), .test_num(test_num), .exp_data(exp_data), .exp_resp(exp_resp),
		.wr_sent(wr_sent), .rd_sent(rd_sent),
		.pass_cnt(pass_cnt), .fail_cnt(fail_cnt), .b_cnt(b_cnt), .r_cnt(r_cnt)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		cycles = 0;
		while (limit == 0 || cycles <= limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout after %0d cycles, test %0d never finished", cycles, test_num);
		$display("TB FAILED");
		$finish;
	end

	task automatic write_reg(input axi_regs_pkg::reg_addr_t addr, input logic [31:0] data);
		logic done;
		logic [31:0] rnd;
		@(negedge clk);
		s_awaddr = addr;
		s_wdata = data;
		s_awvalid = 1'b1;
		s_wvalid = 1'b1;
		wr_sent++;
		while (!s_awready && !s_wready)
			@(negedge clk);
		if (s_awready !== s_wready) begin
			$display("awready and wready did not rise together in test %0d", test_num);
			hs_errs++;
		end
		@(negedge clk); // Address and data taken on the edge just passed
		s_awvalid = 1'b0;
		s_wvalid = 1'b0;
		done = 1'b0;
		while (!done) begin
			rnd = $random(seed);
			s_bready = !stall_en || rnd[0];
			done = s_bvalid && s_bready;
			@(negedge clk);
		end
		s_bready = 1'b0;
	endtask

	task automatic read_reg(input axi_regs_pkg::reg_addr_t addr, output logic [31:0] data);
		logic done;
		logic [31:0] rnd;
		@(negedge clk);
		s_araddr = addr;
		s_arvalid = 1'b1;
		rd_sent++;
		while (!s_arready)
			@(negedge clk);
		@(negedge clk);
		s_arvalid = 1'b0;
		done = 1'b0;
		data = '0;
		while (!done) begin
			rnd = $random(seed);
			s_rready = !stall_en || rnd[0];
			done = s_rvalid && s_rready;
			data = s_rdata;
			@(negedge clk);
		end
		s_rready = 1'b0;
	endtask

	// Reads STATUS until the busy bit clears
	task automatic poll_idle(input axi_regs_pkg::reg_addr_t addr);
		logic [31:0] status;
		int reads;
		check_en = 1'b0;
		reads = 0;
		status = 32'h1;
		while (status[0]) begin
			read_reg(addr, status);
			reads++;
		end
		check_en = 1'b1;
		$display("test %0d: divider idle after %0d status reads", test_num, reads);
	endtask

	initial begin
		reset = 1'b1;
		s_awaddr = '0;
		s_awvalid = 1'b0;
		s_wdata = '0;
		s_wstrb = 4'hf;
		s_wvalid = 1'b0;
		s_bready = 1'b0;
		s_araddr = '0;
		s_arvalid = 1'b0;
		s_rready = 1'b0;
		check_en = 1'b1;
		stall_en = 1'b1;
		exp_data = '0;
		exp_resp = '0;
		for (idx = 0; idx < MAX_LINES * 5; idx++)
			stim[idx] = 8'hff;
		$readmemh("verification/gf_stimulus.txt", stim);
		n_tests = 0;
		while (n_tests < MAX_LINES && stim[n_tests*5] != 8'hff)
			n_tests++;
		limit = n_tests * 40 + 100;
		repeat (4) @(negedge clk);
		reset = 1'b0;

		for (idx = 0; idx < n_tests; idx++) begin
			test_num = idx + 1;
			kind = stim[idx*5];
			stall_en = !kind[4]; // Bit 4 keeps the ready lines high
			exp_data = 32'(stim[idx*5+3]);
			exp_resp = stim[idx*5+4][1:0];
			case (kind[3:0])
				4'h1: write_reg(5'(stim[idx*5+1]), 32'(stim[idx*5+2]));
				4'h2: read_reg(5'(stim[idx*5+1]), rd_value);
				4'h3: poll_idle(5'(stim[idx*5+1]));
				default: begin
					$display("Test %0d has an unknown kind 0x%h", test_num, kind);
					bad_lines++;
				end
			endcase
		end
		repeat (4) @(negedge clk); // Room for a stray response to show up

		if (b_cnt != wr_sent)
			$display("Got %0d write responses for %0d write requests", b_cnt, wr_sent);
		if (r_cnt != rd_sent)
			$display("Got %0d read responses for %0d read requests", r_cnt, rd_sent);
		$display("Tests %0d, checks passed %0d, failed %0d, assertion errors %0d",
			n_tests, pass_cnt, fail_cnt, dut_i.ctrl_i.assert_i.err_cnt);
		if (fail_cnt == 0 && bad_lines == 0 && hs_errs == 0 && b_cnt == wr_sent
			&& r_cnt == rd_sent && dut_i.ctrl_i.assert_i.err_cnt == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end
endmodule

// File: verification/tb_checker.sv
`timescale 1ns/1ps

// Compares every B and R channel response with the expected one
module tb_checker (
	input logic clk,
	input logic reset,
	input logic bvalid,
	input logic bready,
	input logic [1:0] bresp,
	input logic rvalid,
	input logic rready,
	input logic [1:0] rresp,
	input logic [31:0] rdata,
	input logic check_en, // Low while STATUS is polled
	input int test_num,
	input logic [31:0] exp_data,
	input logic [1:0] exp_resp,
	input int wr_sent,
	input int rd_sent,
	output int pass_cnt,
	output int fail_cnt,
	output int b_cnt,
	output int r_cnt
);
	bit resp_ok, data_ok;

	function automatic bit value_ok(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		if (exp === act)
			return 1'b1;
		$display("FAILED %s: expected 0x%h, got 0x%h in test %0d", name, exp, act, test_num);
		return 1'b0;
	endfunction

	always @(posedge clk) begin
		if (!reset && bvalid && bready) begin
			b_cnt++;
			if (b_cnt > wr_sent) begin
				$display("Write response in test %0d came without a write request", test_num);
				fail_cnt++;
			end else if (value_ok("bresp", 32'(exp_resp), 32'(bresp))) begin
				$display("test %0d passed: bresp 0x%h", test_num, bresp);
				pass_cnt++;
			end else begin
				fail_cnt++;
			end
		end
		if (!reset && rvalid && rready) begin
			r_cnt++;
			if (r_cnt > rd_sent) begin
				$display("Read response in test %0d came without a read request", test_num);
				fail_cnt++;
			end else if (check_en) begin
				resp_ok = value_ok("rresp", 32'(exp_resp), 32'(rresp));
				data_ok = value_ok("rdata", exp_data, rdata);
				if (resp_ok && data_ok) begin
					$display("test %0d passed: rdata 0x%h rresp 0x%h", test_num, rdata, rresp);
					pass_cnt++;
				end else begin
					fail_cnt++;
				end
			end
		end
	end
endmodule

// File: verification/gf_alu_assert.sv
`timescale 1ns/1ps
`include "gf_defines.svh"

module gf_alu_assert (
	input logic clk,
	input logic reset,
	input logic awvalid, awready, bvalid, bready,
	input logic arvalid, arready, rvalid, rready,
	input logic div_busy
);
	int err_cnt; // Read by the testbench top at the end of the run

	a_aw_hold: assert property (@(posedge clk) disable iff (reset)
		awvalid && !awready |=> awvalid)
		else begin
			$error("awvalid dropped before awready");
			err_cnt++;
		end

	a_ar_hold: assert property (@(posedge clk) disable iff (reset)
		arvalid && !arready |=> arvalid)
		else begin
			$error("arvalid dropped before arready");
			err_cnt++;
		end

	a_b_hold: assert property (@(posedge clk) disable iff (reset)
		bvalid && !bready |=> bvalid)
		else begin
			$error("bvalid dropped before bready");
			err_cnt++;
		end

	a_r_hold: assert property (@(posedge clk) disable iff (reset)
		rvalid && !rready |=> rvalid)
		else begin
			$error("rvalid dropped before rready");
			err_cnt++;
		end

	// Busy high for exactly the step count, low the cycle before
	a_busy_len: assert property (@(posedge clk) disable iff (reset)
		$fell(div_busy) |-> $past(div_busy, `GF_DIV_STEPS) && !$past(div_busy, `GF_DIV_STEPS + 1))
		else begin
			$error("divider busy length differs from the step count");
			err_cnt++;
		end

	a_r_cause: assert property (@(posedge clk) disable iff (reset)
		$rose(rvalid) |-> $past(arvalid && arready))
		else begin
			$error("read response without an accepted read address");
			err_cnt++;
		end

	a_b_cause: assert property (@(posedge clk) disable iff (reset)
		$rose(bvalid) |-> $past(awvalid && awready))
		else begin
			$error("write response without an accepted write address");
			err_cnt++;
		end
endmodule

bind gf_ctrl gf_alu_assert assert_i (
	.clk(clk),
	.reset(reset),
	.awvalid(awvalid),
	.awready(awready),
	.bvalid(bvalid),
	.bready(bready),
	.arvalid(arvalid),
	.arready(arready),
	.rvalid(rvalid),
	.rready(rready),
	.div_busy(div.busy)
);

// File: rtl/gf_alu_top.sv
`timescale 1ns/1ps
`include "gf_defines.svh"

module gf_alu_top (
	input logic clk,
	input logic reset,
	input axi_regs_pkg::reg_addr_t s_awaddr,
	input logic s_awvalid,
	output logic s_awready,
	input logic [31:0] s_wdata,
	input logic [3:0] s_wstrb, // Ignored, only the low byte is stored
	input logic s_wvalid,
	output logic s_wready,
	output axi_regs_pkg::axi_resp_t s_bresp,
	output logic s_bvalid,
	input logic s_bready,
	input axi_regs_pkg::reg_addr_t s_araddr,
	input logic s_arvalid,
	output logic s_arready,
	output logic [31:0] s_rdata,
	output axi_regs_pkg::axi_resp_t s_rresp,
	output logic s_rvalid,
	input logic s_rready
);
	gf_types_pkg::gf_elem_t mul_a, mul_b, mul_p;

	gf_div_if div_if ();

	gf_ctrl ctrl_i (
		.clk(clk),
		.reset(reset),
		.awaddr(s_awaddr),
		.awvalid(s_awvalid),
		.awready(s_awready),
		.wdata(s_wdata),
		.wvalid(s_wvalid),
		.wready(s_wready),
		.bresp(s_bresp),
		.bvalid(s_bvalid),
		.bready(s_bready),
		.araddr(s_araddr),
		.arvalid(s_arvalid),
		.arready(s_arready),
		.rdata(s_rdata),
		.rresp(s_rresp),
		.rvalid(s_rvalid),
		.rready(s_rready),
		.mul_a(mul_a),
		.mul_b(mul_b),
		.mul_p(mul_p),
		.div(div_if.ctrl)
	);

	gf_mult mult_i (
		.a(mul_a),
		.b(mul_b),
		.p(mul_p)
	);

	gf_divider divider_i (
		.clk(clk),
		.reset(reset),
		.div(div_if.dvd)
	);
endmodule

// File: rtl/gf_ctrl.sv
`timescale 1ns/1ps
`include "gf_defines.svh"

module gf_ctrl (
	input logic clk,
	input logic reset,
	input axi_regs_pkg::reg_addr_t awaddr,
	input logic awvalid,
	output logic awready,
	input logic [31:0] wdata,
	input logic wvalid,
	output logic wready,
	output axi_regs_pkg::axi_resp_t bresp,
	output logic bvalid,
	input logic bready,
	input axi_regs_pkg::reg_addr_t araddr,
	input logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output axi_regs_pkg::axi_resp_t rresp,
	output logic rvalid,
	input logic rready,
	output gf_types_pkg::gf_elem_t mul_a,
	output gf_types_pkg::gf_elem_t mul_b,
	input gf_types_pkg::gf_elem_t mul_p,
	gf_div_if.ctrl div
);
	axi_regs_pkg::ctrl_state_t state;
	axi_regs_pkg::axi_resp_t rd_resp;
	gf_types_pkg::gf_elem_t a_q, b_q, result_q;
	gf_types_pkg::gf_elem_t numer_q, denom_q;
	gf_types_pkg::gf_op_t op_q, wr_op;
	logic [31:0] rd_data;
	logic dz_q, busy, start_q;
	logic wr_en, wr_ok, rd_en;

	assign busy = (state == axi_regs_pkg::ST_DIV_WAIT);
	assign wr_en = awready && awvalid && wready && wvalid;
	assign rd_en = arready && arvalid;
	assign wr_op = gf_types_pkg::gf_op_t'(wdata[1:0]);

	assign mul_a = a_q; // Multiplier always sees the operand registers
	assign mul_b = b_q;
	assign div.start = start_q;
	assign div.numer = numer_q;
	assign div.denom = denom_q;

	always_comb begin
		case (awaddr)
			`REG_A, `REG_B: wr_ok = 1'b1;
			`REG_CTRL: wr_ok = !busy; // Rejected while a division runs
			default: wr_ok = 1'b0; // STATUS, RESULT and holes
		endcase
	end

	// Write address and data are taken together, one at a time
	always_ff @(posedge clk) begin
		if (reset) begin
			awready <= 1'b0;
			wready <= 1'b0;
			bvalid <= 1'b0;
			bresp <= axi_regs_pkg::RESP_OKAY;
		end else begin
			awready <= !awready && !bvalid && awvalid && wvalid;
			wready <= !awready && !bvalid && awvalid && wvalid;
			if (wr_en) begin
				bvalid <= 1'b1;
				bresp <= wr_ok ? axi_regs_pkg::RESP_OKAY : axi_regs_pkg::RESP_SLVERR;
			end else if (bready) begin
				bvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= axi_regs_pkg::ST_IDLE;
			a_q <= '0;
			b_q <= '0;
			result_q <= '0;
			op_q <= gf_types_pkg::OP_ADD;
			dz_q <= 1'b0;
			start_q <= 1'b0;
		end else begin
			start_q <= 1'b0;
			if (wr_en && wr_ok) begin
				case (awaddr)
					`REG_A: a_q <= wdata[`GF_M-1:0];
					`REG_B: b_q <= wdata[`GF_M-1:0];
					`REG_CTRL: begin
						op_q <= wr_op;
						dz_q <= 1'b0;
						case (wr_op)
							gf_types_pkg::OP_ADD: result_q <= a_q ^ b_q;
							gf_types_pkg::OP_MUL: result_q <= mul_p;
							default: begin
								if (b_q == '0) begin
									dz_q <= 1'b1; // Divider is skipped
									result_q <= '0;
								end else begin
									start_q <= 1'b1;
									state <= axi_regs_pkg::ST_DIV_WAIT;
								end
							end
						endcase
					end
					default: ;
				endcase
			end
			// start_q still high means the divider has not raised busy yet
			if (busy && !start_q && !div.busy) begin
				result_q <= div.quot;
				state <= axi_regs_pkg::ST_IDLE;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en && wr_ok && awaddr == `REG_CTRL) begin
			numer_q <= (wr_op == gf_types_pkg::OP_INV) ? gf_types_pkg::gf_elem_t'(1) : a_q;
			denom_q <= b_q;
		end
	end

	always_comb begin
		rd_data = '0;
		rd_resp = axi_regs_pkg::RESP_OKAY;
		case (araddr)
			`REG_A: rd_data[`GF_M-1:0] = a_q;
			`REG_B: rd_data[`GF_M-1:0] = b_q;
			`REG_CTRL: rd_data[1:0] = op_q;
			`REG_STATUS: rd_data[1:0] = {dz_q, busy};
			`REG_RESULT: rd_data[`GF_M-1:0] = result_q; // Old value while busy
			default: rd_resp = axi_regs_pkg::RESP_SLVERR;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			arready <= 1'b0;
			rvalid <= 1'b0;
			rresp <= axi_regs_pkg::RESP_OKAY;
			rdata <= '0;
		end else begin
			arready <= !arready && !rvalid && arvalid;
			if (rd_en) begin
				rvalid <= 1'b1;
				rdata <= rd_data;
				rresp <= rd_resp;
			end else if (rready) begin
				rvalid <= 1'b0;
			end
		end
	end
endmodule

// File: rtl/gf_divider.sv
`timescale 1ns/1ps
`include "gf_defines.svh"

// Fermat inversion: 1/b = b^254 = b^2 * b^4 * ... * b^128
module gf_divider (
	input logic clk,
	input logic reset,
	gf_div_if.dvd div
);
	localparam int CNT_W = $clog2(`GF_DIV_STEPS);

	gf_types_pkg::gf_elem_t pow_q, acc_q, numer_q;
	gf_types_pkg::gf_elem_t sq_in, sq_out, acc_in, acc_out;
	logic [CNT_W-1:0] step_q;
	logic busy_q, last_step;

	assign last_step = (step_q == CNT_W'(`GF_DIV_STEPS - 1));

	assign sq_in = div.start ? div.denom : pow_q; // Current power b^(2^i)
	assign acc_in = last_step ? numer_q : pow_q; // Numerator folded in at the end

	gf_mult sq_i (
		.a(sq_in),
		.b(sq_in),
		.p(sq_out)
	);

	gf_mult acc_i (
		.a(acc_q),
		.b(acc_in),
		.p(acc_out)
	);

	assign div.quot = acc_q;
	assign div.busy = busy_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			busy_q <= 1'b0;
			step_q <= '0;
		end else if (div.start) begin
			busy_q <= 1'b1;
			step_q <= '0;
		end else if (busy_q) begin
			step_q <= step_q + 1'b1;
			if (last_step)
				busy_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (div.start) begin
			pow_q <= sq_out; // b^2
			acc_q <= gf_types_pkg::gf_elem_t'(1);
			numer_q <= div.numer;
		end else if (busy_q) begin
			acc_q <= acc_out;
			pow_q <= sq_out;
		end
	end
endmodule

// File: rtl/gf_mult.sv
`timescale 1ns/1ps
`include "gf_defines.svh"

// Bit-parallel standard basis multiplier, purely combinational
module gf_mult (
	input gf_types_pkg::gf_elem_t a,
	input gf_types_pkg::gf_elem_t b,
	output gf_types_pkg::gf_elem_t p
);
	gf_types_pkg::gf_elem_t chain [`GF_M]; // chain[i] = a * alpha^i

	genvar i, j;

	assign chain[0] = a;

	generate
		for (i = 1; i < `GF_M; i = i + 1) begin : g_chain
			// Shift up one power and fold the overflow back through the polynomial
			assign chain[i] = {chain[i-1][`GF_M-2:0], 1'b0}
				^ ({`GF_M{chain[i-1][`GF_M-1]}} & `GF_POLY);
		end

		for (i = 0; i < `GF_M; i = i + 1) begin : g_out
			logic [`GF_M-1:0] col; // Bit i of every chain term

			for (j = 0; j < `GF_M; j = j + 1) begin : g_col
				assign col[j] = chain[j][i];
			end

			assign p[i] = ^(col & b); // Sum of b[j] * a * alpha^j
		end
	endgenerate
endmodule

// File: rtl/gf_div_if.sv
`timescale 1ns/1ps
`include "gf_defines.svh"

interface gf_div_if;
	logic start; // One-cycle pulse, operands sampled with it
	gf_types_pkg::gf_elem_t numer;
	gf_types_pkg::gf_elem_t denom;
	gf_types_pkg::gf_elem_t quot; // Held from busy falling until next start
	logic busy;

	modport ctrl (
		output start, numer, denom,
		input quot, busy
	);

	modport dvd (
		input start, numer, denom,
		output quot, busy
	);
endinterface

// File: rtl/axi_regs_pkg.sv
`include "gf_defines.svh"

package axi_regs_pkg;

	typedef logic [4:0] reg_addr_t; // Register byte offset

	typedef enum logic [1:0] {
		RESP_OKAY = 2'b00,
		RESP_SLVERR = 2'b10
	} axi_resp_t;

	typedef enum logic {
		ST_IDLE,
		ST_DIV_WAIT // Division running in the divider
	} ctrl_state_t;

endpackage

// File: rtl/gf_types_pkg.sv
`include "gf_defines.svh"

package gf_types_pkg;

	// Standard basis, bit i is the coefficient of alpha^i
	typedef logic [`GF_M-1:0] gf_elem_t;

	typedef enum logic [1:0] {
		OP_ADD = 2'd0,
		OP_MUL = 2'd1,
		OP_DIV = 2'd2, // A / B
		OP_INV = 2'd3 // 1 / B
	} gf_op_t;

endpackage

// File: rtl/gf_defines.svh
`ifndef GF_DEFINES_SVH
`define GF_DEFINES_SVH

`define GF_M 8 // Field width in bits
// Low byte of x^8+x^4+x^3+x^2+1
`define GF_POLY 8'h1D
`define GF_DIV_STEPS 8 // Busy cycles per division

`define REG_A 5'h00
`define REG_B 5'h04
`define REG_CTRL 5'h08 // Op code in bits 1:0
`define REG_STATUS 5'h0C // Bit 0 busy, bit 1 divide by zero
`define REG_RESULT 5'h10

`endif
